//--- all.f
hdl/fabric_pkg.sv
hdl/switch_box.sv
hdl/connection_box.sv
hdl/logic_block.sv
hdl/fabric_tile.sv
test/fabric_tile_properties.sv
test/fabric_tile_tb.sv

//--- hdl/connection_box.sv
// connection_box: picks the four lookup-table inputs out of the sixteen
// incoming routing tracks
`default_nettype none

module connection_box
   import fabric_pkg::*;
(
   input  wire          clk,
   input  wire          rst,

   input  wire          config_en,
   input  config_word_t config_data,

   input  track_t       side_0_in,
   input  track_t       side_1_in,
   input  track_t       side_2_in,
   input  track_t       side_3_in,

   output lut_in_t      lut_in
);

   // four bits per lookup-table input, each naming one flattened track
   logic [15:0]           sel_q;
   logic [num_tracks-1:0] tracks;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         sel_q <= '0;
      end else if (config_en) begin
         sel_q <= config_data[15:0];
      end
   end

   // flattened track index is 4 * side + track
   assign tracks = {side_3_in, side_2_in, side_1_in, side_0_in};

   always_comb begin
      for (int j = 0; j < 4; j++) begin
         lut_in[j] = tracks[sel_q[4*j +: 4]];
      end
   end

endmodule

`default_nettype wire

//--- hdl/fabric_pkg.sv
// fabric_pkg: tile geometry, configuration addresses and the vector types
// shared by the switch box, connection box and logic block
`default_nettype none

package fabric_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // sides are numbered 0 east, 1 south, 2 west, 3 north
   localparam int num_sides       = 4;
   localparam int tracks_per_side = 4;
   localparam int num_tracks      = num_sides * tracks_per_side;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [tracks_per_side-1:0] track_t;
   typedef logic [1:0]                 side_sel_t;
   typedef logic [31:0]                config_word_t;
   typedef logic [1:0]                 config_addr_t;
   typedef logic [3:0]                 lut_in_t;
   typedef logic [15:0]                lut_mask_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // configuration addresses
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // address 3 selects nothing and writes to it are dropped
   localparam config_addr_t cfg_addr_sb = 2'd0;
   localparam config_addr_t cfg_addr_cb = 2'd1;
   localparam config_addr_t cfg_addr_lb = 2'd2;

endpackage

`default_nettype wire

//--- hdl/fabric_tile.sv
// fabric_tile: one fabric tile with configuration write decode and the
// switch box, connection box and logic block
`default_nettype none

module fabric_tile
   import fabric_pkg::*;
(
   input  wire          clk,
   input  wire          rst,

   // configuration port, one word per cycle
   input  wire          config_en,
   input  config_addr_t config_addr,
   input  config_word_t config_data,

   input  track_t       side_0_in,
   input  track_t       side_1_in,
   input  track_t       side_2_in,
   input  track_t       side_3_in,

   output track_t       side_0_out,
   output track_t       side_1_out,
   output track_t       side_2_out,
   output track_t       side_3_out
);

   logic    sb_config_en;
   logic    cb_config_en;
   logic    lb_config_en;

   lut_in_t lut_in;
   logic    clb_result;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // configuration address decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // address 3 matches none of these, so such writes are dropped
   assign sb_config_en = config_en && (config_addr == cfg_addr_sb);
   assign cb_config_en = config_en && (config_addr == cfg_addr_cb);
   assign lb_config_en = config_en && (config_addr == cfg_addr_lb);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // blocks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // tracks only flow from the side inputs into the connection box, so the
   // result fed back into the switch box cannot close a loop
   connection_box u_cb (
      .clk         (clk),
      .rst         (rst),
      .config_en   (cb_config_en),
      .config_data (config_data),
      .side_0_in   (side_0_in),
      .side_1_in   (side_1_in),
      .side_2_in   (side_2_in),
      .side_3_in   (side_3_in),
      .lut_in      (lut_in)
   );

   logic_block u_lb (
      .clk         (clk),
      .rst         (rst),
      .config_en   (lb_config_en),
      .config_data (config_data),
      .lut_in      (lut_in),
      .clb_result  (clb_result)
   );

   switch_box u_sb (
      .clk         (clk),
      .rst         (rst),
      .config_en   (sb_config_en),
      .config_data (config_data),
      .side_0_in   (side_0_in),
      .side_1_in   (side_1_in),
      .side_2_in   (side_2_in),
      .side_3_in   (side_3_in),
      .clb_result  (clb_result),
      .side_0_out  (side_0_out),
      .side_1_out  (side_1_out),
      .side_2_out  (side_2_out),
      .side_3_out  (side_3_out)
   );

endmodule

`default_nettype wire

//--- hdl/logic_block.sv
// logic_block: 4-input lookup table with an optional output flip-flop
`default_nettype none

module logic_block
   import fabric_pkg::*;
(
   input  wire          clk,
   input  wire          rst,

   input  wire          config_en,
   input  config_word_t config_data,

   input  lut_in_t      lut_in,

   output logic         clb_result
);

   lut_mask_t mask_q;
   logic      reg_en_q;

   logic      lut_bit;
   logic      lut_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // configuration
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // truth table in bits 15 to 0, output register enable in bit 16
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mask_q   <= '0;
         reg_en_q <= 1'b0;
      end else if (config_en) begin
         mask_q   <= config_data[15:0];
         reg_en_q <= config_data[16];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // lookup and output register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign lut_bit = mask_q[lut_in];

   // the flip-flop samples every cycle whether or not it is selected
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         lut_q <= 1'b0;
      end else begin
         lut_q <= lut_bit;
      end
   end

   assign clb_result = reg_en_q ? lut_q : lut_bit;

endmodule

`default_nettype wire

//--- hdl/switch_box.sv
// switch_box: four-sided routing switch with its configuration register
// and injection of the logic-block result on own-side codes
`default_nettype none

//                3
//
//   2       switch_box       0
//
//                1

module switch_box
   import fabric_pkg::*;
(
   input  wire          clk,
   input  wire          rst,

   input  wire          config_en,
   input  config_word_t config_data,

   input  track_t       side_0_in,
   input  track_t       side_1_in,
   input  track_t       side_2_in,
   input  track_t       side_3_in,

   input  wire          clb_result,

   output track_t       side_0_out,
   output track_t       side_1_out,
   output track_t       side_2_out,
   output track_t       side_3_out
);

   // two select bits for each of the sixteen output tracks
   config_word_t config_q;

   track_t side_in  [num_sides];
   track_t side_out [num_sides];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         config_q <= '0;
      end else if (config_en) begin
         config_q <= config_data;
      end
   end

   assign side_in[0] = side_0_in;
   assign side_in[1] = side_1_in;
   assign side_in[2] = side_2_in;
   assign side_in[3] = side_3_in;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // track selection
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // output track t of side s takes track t of the coded side
   // a code naming the output's own side would be a U-turn, so the
   // logic block result is driven there instead
   always_comb begin
      side_sel_t code;
      int        k;
      for (int s = 0; s < num_sides; s++) begin
         for (int t = 0; t < tracks_per_side; t++) begin
            k    = tracks_per_side * s + t;
            code = config_q[2*k +: 2];
            if (code == side_sel_t'(s)) begin
               side_out[s][t] = clb_result;
            end else begin
               side_out[s][t] = side_in[code][t];
            end
         end
      end
   end

   assign side_0_out = side_out[0];
   assign side_1_out = side_out[1];
   assign side_2_out = side_out[2];
   assign side_3_out = side_out[3];

endmodule

`default_nettype wire

//--- test/fabric_tile_properties.sv
// fabric_tile_properties: assertions on configuration write decode and
// configuration register hold, bound into fabric_tile
`default_nettype none

module fabric_tile_properties
   import fabric_pkg::*;
(
   input wire          clk,
   input wire          rst,
   input wire          config_en,
   input config_addr_t config_addr,
   input wire          sb_config_en,
   input wire          cb_config_en,
   input wire          lb_config_en,
   input config_word_t sb_config_q,
   input wire [15:0]   cb_sel_q,
   input lut_mask_t    lb_mask_q,
   input wire          lb_reg_en_q
);

   // number of assertion failures seen so far
   int fail_count = 0;

   // at most one block is written in any cycle
   assert property (@(posedge clk) disable iff (!rst)
      $onehot0({sb_config_en, cb_config_en, lb_config_en}))
      else begin
         $error("more than one configuration write enable is high");
         fail_count++;
      end

   // no write without the strobe, and none to the unused address
   assert property (@(posedge clk) disable iff (!rst)
      (!config_en || config_addr == 2'd3) |-> !(sb_config_en || cb_config_en || lb_config_en))
      else begin
         $error("write enable high without a valid configuration write");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (!rst)
      !sb_config_en |=> $stable(sb_config_q))
      else begin
         $error("switch box configuration changed without a write");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (!rst)
      !cb_config_en |=> $stable(cb_sel_q))
      else begin
         $error("connection box configuration changed without a write");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (!rst)
      !lb_config_en |=> ($stable(lb_mask_q) && $stable(lb_reg_en_q)))
      else begin
         $error("logic block configuration changed without a write");
         fail_count++;
      end

endmodule

bind fabric_tile fabric_tile_properties u_props (
   .clk          (clk),
   .rst          (rst),
   .config_en    (config_en),
   .config_addr  (config_addr),
   .sb_config_en (sb_config_en),
   .cb_config_en (cb_config_en),
   .lb_config_en (lb_config_en),
   .sb_config_q  (u_sb.config_q),
   .cb_sel_q     (u_cb.sel_q),
   .lb_mask_q    (u_lb.mask_q),
   .lb_reg_en_q  (u_lb.reg_en_q)
);

`default_nettype wire

//--- test/fabric_tile_tb.sv
// fabric_tile_tb: clocked random stimulus for one fabric tile, checked
// against a model of the configuration registers and routing rules
`default_nettype none

module fabric_tile_tb
   import fabric_pkg::*;
();

   localparam int max_cycles = 3000;

   logic         clk;
   logic         rst;
   logic         config_en;
   config_addr_t config_addr;
   config_word_t config_data;
   track_t       side_in [num_sides];
   track_t       side_0_out;
   track_t       side_1_out;
   track_t       side_2_out;
   track_t       side_3_out;

   // model copies of the three configuration words and the output flip-flop
   config_word_t m_sb;
   config_word_t m_cb;
   config_word_t m_lb;
   logic         m_ff;

   logic [31:0]  lfsr;
   int           cycle_count;
   int           error_count;

   fabric_tile u_dut (
      .clk         (clk),
      .rst         (rst),
      .config_en   (config_en),
      .config_addr (config_addr),
      .config_data (config_data),
      .side_0_in   (side_in[0]),
      .side_1_in   (side_in[1]),
      .side_2_in   (side_in[2]),
      .side_3_in   (side_in[3]),
      .side_0_out  (side_0_out),
      .side_1_out  (side_1_out),
      .side_2_out  (side_2_out),
      .side_3_out  (side_3_out)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // random numbers and model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // galois LFSR, one step for every bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hb4bc_d35c) : (lfsr >> 1);
      end
      return v;
   endfunction

   // flattened track index is 4 * side + track
   function automatic logic expect_lut_bit();
      logic [15:0] flat;
      lut_in_t     idx;
      flat = {side_in[3], side_in[2], side_in[1], side_in[0]};
      for (int j = 0; j < 4; j++) begin
         idx[j] = flat[m_cb[4*j +: 4]];
      end
      return m_lb[idx];
   endfunction

   function automatic logic expect_result();
      return m_lb[16] ? m_ff : expect_lut_bit();
   endfunction

   function automatic track_t expect_side(input int s);
      track_t    v;
      side_sel_t code;
      int        k;
      for (int t = 0; t < tracks_per_side; t++) begin
         k    = tracks_per_side * s + t;
         code = m_sb[2*k +: 2];
         v[t] = (code == side_sel_t'(s)) ? expect_result() : side_in[code][t];
      end
      return v;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic abort_run();
      error_count++;
      $display("TB FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_track(input track_t got, input track_t expected, input int side);
      if (got !== expected) begin
         $display("FAIL %0t: side %0d output %b, expected %b", $time, side, got, expected);
         abort_run();
      end
   endtask

   task automatic check_result(input logic got, input logic expected);
      if (got !== expected) begin
         $display("FAIL %0t: logic block result %b, expected %b", $time, got, expected);
         abort_run();
      end
   endtask

   task automatic check_outputs();
      check_track(side_0_out, expect_side(0), 0);
      check_track(side_1_out, expect_side(1), 1);
      check_track(side_2_out, expect_side(2), 2);
      check_track(side_3_out, expect_side(3), 3);
      // side 0 track 0 carries the result whenever its code is the own side
      if (m_sb[1:0] == 2'd0) begin
         check_result(side_0_out[0], expect_result());
      end
   endtask

   // the bound checker counts its own assertion failures
   task automatic scan_assertion_failures();
      if (u_dut.u_props.fail_count != 0) begin
         $display("a bound assertion on the tile's configuration logic failed");
         abort_run();
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // entered 2 units after a rising edge, checks just before the next one
   task automatic drive_cycle(input logic en, input config_addr_t addr, input config_word_t data);
      config_en   = en;
      config_addr = addr;
      config_data = data;
      for (int s = 0; s < num_sides; s++) begin
         side_in[s] = track_t'(rand_bits(tracks_per_side));
      end
      #16;
      check_outputs();
      scan_assertion_failures();
      @(posedge clk);
      m_ff = expect_lut_bit();
      if (en) begin
         case (addr)
            cfg_addr_sb: m_sb = data;
            cfg_addr_cb: m_cb = data;
            cfg_addr_lb: m_lb = data;
            default: ;
         endcase
      end
      #2;
   endtask

   task automatic idle_cycles(input int n);
      config_addr_t a;
      config_word_t d;
      for (int i = 0; i < n; i++) begin
         a = config_addr_t'(rand_bits(2));
         d = rand_bits(32);
         drive_cycle(1'b0, a, d);
      end
   endtask

   // random connection box and truth table, side 0 track 0 forced to its own side
   task automatic load_function(input logic reg_en);
      config_word_t d;
      d = rand_bits(32);
      drive_cycle(1'b1, cfg_addr_cb, d);
      d = rand_bits(32);
      d[16] = reg_en;
      drive_cycle(1'b1, cfg_addr_lb, d);
      d = rand_bits(32);
      d[1:0] = 2'd0;
      drive_cycle(1'b1, cfg_addr_sb, d);
   endtask

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clk);
         cycle_count++;
         if (cycle_count >= max_cycles) begin
            $display("timeout: the run went past %0d clock cycles", max_cycles);
            abort_run();
         end
      end
   end

   initial begin
      config_word_t d;
      logic         en;
      lfsr        = 32'h8f63_fd24;
      error_count = 0;
      rst         = 1'b0;
      config_en   = 1'b0;
      config_addr = '0;
      config_data = '0;
      for (int s = 0; s < num_sides; s++) begin
         side_in[s] = '0;
      end
      m_sb = '0;
      m_cb = '0;
      m_lb = '0;
      m_ff = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b1;

      // reset state with random side inputs
      idle_cycles(20);

      // random switch box words
      for (int i = 0; i < 60; i++) begin
         d = rand_bits(32);
         drive_cycle(1'b1, cfg_addr_sb, d);
         idle_cycles(8);
      end

      // combinational then registered logic block result
      for (int i = 0; i < 30; i++) begin
         load_function(1'b0);
         idle_cycles(8);
      end
      for (int i = 0; i < 30; i++) begin
         load_function(1'b1);
         idle_cycles(8);
      end

      // writes to address 3 and data without the strobe change nothing
      for (int i = 0; i < 600; i++) begin
         en = (rand_bits(1) != '0);
         d  = rand_bits(32);
         if (en) begin
            drive_cycle(1'b1, 2'd3, d);
         end else begin
            idle_cycles(1);
         end
      end

      scan_assertion_failures();

      if (error_count == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         abort_run();
      end
   end

endmodule

`default_nettype wire
